// ==== Makefile ====
TOP = alu900_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f alu900.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// ==== alu900.f ====
+incdir+logic
logic/alu900_pkg.sv
logic/alu900_decode.sv
logic/alu900_arith.sv
logic/alu900_bitops.sv
logic/alu900_result.sv
logic/alu900_top.sv
verif/alu900_tb.sv

// ==== logic/alu900_arith.sv ====
//****************************************
// ALU900 adder-subtractor with chained
// half, byte, word and long carries
//****************************************

`default_nettype none

`include "alu900_config.svh"

module alu900_arith import alu900_pkg::*; (
    input  alu_ctl_t              ctl,
    input  logic [`ALU900_DW-1:0] op0,
    input  logic [`ALU900_DW-1:0] op2,
    input  logic                  carry,
    output raw_res_t              res
);

    logic                  cin;
    logic [4:0]            s_lo;    // bits 3:0, carry is H
    logic [4:0]            s_hi;    // bits 7:4
    logic [8:0]            s_b1;    // bits 15:8
    logic [16:0]           s_hw;    // bits 31:16
    logic [`ALU900_DW-1:0] sum;

    // signed overflow from the operand and result sign bits
    function automatic logic ovf(input logic a, input logic b, input logic r,
                                 input logic sub);
        logic same_sign;
        same_sign = sub ? (a ^ b) : ~(a ^ b);
        return same_sign & (r ^ a);
    endfunction

    assign cin = ctl.use_carry & carry;

    always_comb begin
        if (ctl.sub) begin
            // borrows ripple in the carry bits
            s_lo = {1'b0, op0[3:0]} - {1'b0, op2[3:0]} - {4'd0, cin};
            s_hi = {1'b0, op0[7:4]} - {1'b0, op2[7:4]} - {4'd0, s_lo[4]};
            s_b1 = {1'b0, op0[15:8]} - {1'b0, op2[15:8]} - {8'd0, s_hi[4]};
            s_hw = {1'b0, op0[31:16]} - {1'b0, op2[31:16]} - {16'd0, s_b1[8]};
        end else begin
            s_lo = {1'b0, op0[3:0]} + {1'b0, op2[3:0]} + {4'd0, cin};
            s_hi = {1'b0, op0[7:4]} + {1'b0, op2[7:4]} + {4'd0, s_lo[4]};
            s_b1 = {1'b0, op0[15:8]} + {1'b0, op2[15:8]} + {8'd0, s_hi[4]};
            s_hw = {1'b0, op0[31:16]} + {1'b0, op2[31:16]} + {16'd0, s_b1[8]};
        end
    end

    assign sum = {s_hw[15:0], s_b1[7:0], s_hi[3:0], s_lo[3:0]};

    always_comb begin
        res       = '0;
        res.value = ctl.op == ALU_MOVE ? op2 : sum;
        res.half  = s_lo[4];
        res.cy    = {s_hw[16], s_b1[8], s_hi[4]};
        res.ov[0] = ovf(op0[7], op2[7], sum[7], ctl.sub);
        res.ov[1] = ovf(op0[15], op2[15], sum[15], ctl.sub);
        res.ov[2] = ovf(op0[31], op2[31], sum[31], ctl.sub);
        // c_out and z_out only come from bitops
    end

endmodule

`default_nettype wire

// ==== logic/alu900_bitops.sv ====
//****************************************
// ALU900 logic, single-step rotate/shift,
// bit and carry-flag operations
//****************************************

`default_nettype none

`include "alu900_config.svh"

module alu900_bitops import alu900_pkg::*; (
    input  alu_ctl_t              ctl,
    input  logic [`ALU900_DW-1:0] op0,
    input  logic [`ALU900_DW-1:0] op2,
    input  flags_t                cur,
    output raw_res_t              res
);

    logic [`ALU900_BIX_W-1:0] idx;
    logic                     bit_at;   // indexed bit of op0
    logic [`ALU900_DW-1:0]    onehot;
    logic                     sign;     // msb at the current width
    logic                     ins_l;
    logic                     ins_r;
    logic [`ALU900_DW-1:0]    shl;
    logic [`ALU900_DW-1:0]    shr;

    assign idx    = op2[`ALU900_BIX_W-1:0];
    assign bit_at = op0[idx];
    assign onehot = {{(`ALU900_DW-1){1'b0}}, 1'b1} << idx;

    always_comb begin
        if (ctl.w.byte_w)
            sign = op0[7];
        else if (ctl.w.word_w)
            sign = op0[15];
        else
            sign = op0[31];
    end

    // bit coming in at the lsb / msb
    always_comb begin
        case (ctl.op)
            ALU_RL:  ins_l = cur.c;
            ALU_RLC: ins_l = sign;
            default: ins_l = 1'b0;
        endcase
        case (ctl.op)
            ALU_RR:  ins_r = cur.c;
            ALU_RRC: ins_r = op0[0];
            ALU_SRA: ins_r = sign;
            default: ins_r = 1'b0;
        endcase
    end

    assign shl = {op0[`ALU900_DW-2:0], ins_l};

    always_comb begin
        shr = op0 >> 1;
        if (ctl.w.byte_w)
            shr[7] = ins_r;
        else if (ctl.w.word_w)
            shr[15] = ins_r;
        else
            shr[31] = ins_r;
    end

    always_comb begin
        res       = '0;
        res.value = op0;    // register unchanged by default
        case (ctl.op)
            ALU_AND: res.value = op0 & op2;
            ALU_OR:  res.value = op0 | op2;
            ALU_XOR: res.value = op0 ^ op2;
            ALU_CPL: res.value = ~op2;
            ALU_RL, ALU_RLC, ALU_SLA, ALU_SLL: begin
                res.value = shl;
                res.c_out = sign;
            end
            ALU_RR, ALU_RRC, ALU_SRA, ALU_SRL: begin
                res.value = shr;
                res.c_out = op0[0];
            end
            ALU_BIT: res.z_out = ~bit_at;
            ALU_SET: res.value = op0 | onehot;
            ALU_RES: res.value = op0 & ~onehot;
            ALU_CHG: res.value = op0 ^ onehot;
            ALU_TSET: begin
                res.value = op0 | onehot;
                res.z_out = ~bit_at;    // tested before the set
            end
            ALU_SCF:   res.c_out = 1'b1;
            ALU_CCF:   res.c_out = ~cur.c;
            ALU_ZCF:   res.c_out = ~cur.z;
            ALU_LDCF:  res.c_out = bit_at;
            ALU_ANDCF: res.c_out = cur.c & bit_at;
            ALU_ORCF:  res.c_out = cur.c | bit_at;
            ALU_XORCF: res.c_out = cur.c ^ bit_at;
            default: ;  // RCF and logic ops leave c_out at 0
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/alu900_config.svh ====
//****************************************
// ALU900 build constants: data width,
// opcode width and bit-index width
//****************************************

`ifndef ALU900_CONFIG_SVH
`define ALU900_CONFIG_SVH

// datapath width, long operands
`define ALU900_DW 32

// opcode field width
`define ALU900_SEL_W 6

// bit index into the low halfword
`define ALU900_BIX_W 4

`endif

// ==== logic/alu900_decode.sv ====
//****************************************
// ALU900 opcode decode and second
// operand select
//****************************************

`default_nettype none

`include "alu900_config.svh"

module alu900_decode import alu900_pkg::*; (
    input  alu_op_e               op,
    input  width_t                w,
    input  logic                  sel_imm,
    input  logic [`ALU900_DW-1:0] op1,
    input  logic [`ALU900_DW-1:0] imm,
    output alu_ctl_t              ctl,
    output logic [`ALU900_DW-1:0] op2
);

    localparam flag_mask_t MASK_ALL  = 6'b111111;
    localparam flag_mask_t MASK_NO_C = 6'b111110;
    localparam flag_mask_t MASK_ZHN  = 6'b011010;   // bit test ops
    localparam flag_mask_t MASK_HVN  = 6'b001110;
    localparam flag_mask_t MASK_HNC  = 6'b001011;
    localparam flag_mask_t MASK_NC   = 6'b000011;
    localparam flag_mask_t MASK_C    = 6'b000001;

    assign op2 = sel_imm ? imm : op1;

    always_comb begin
        ctl       = '0;
        ctl.op    = op;
        ctl.w     = w;
        ctl.v_src = V_KEEP;
        ctl.h_fix = H_CALC;
        case (op)
            ALU_MOVE: ctl.is_arith = 1'b1;    // op2 passes through, no flags
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP: begin
                ctl.is_arith  = 1'b1;
                ctl.sub       = op inside {ALU_SUB, ALU_SBC, ALU_CP};
                ctl.use_carry = op inside {ALU_ADC, ALU_SBC};
                ctl.v_src     = V_OVF;
                ctl.n_val     = ctl.sub;
                ctl.mask      = MASK_ALL;
            end
            ALU_INC, ALU_DEC: begin
                ctl.is_arith = 1'b1;
                ctl.sub      = op == ALU_DEC;
                ctl.v_src    = V_OVF;
                ctl.n_val    = ctl.sub;
                // flags only move at byte width, C never
                ctl.mask     = w.byte_w ? MASK_NO_C : '0;
            end
            ALU_AND, ALU_OR, ALU_XOR: begin
                ctl.v_src       = V_PAR;
                ctl.h_fix       = op == ALU_AND ? H_ONE : H_ZERO;
                ctl.c_from_unit = 1'b1;     // unit clears C
                ctl.mask        = MASK_ALL;
            end
            ALU_CPL: begin
                ctl.v_src = V_PAR;
                ctl.h_fix = H_ONE;
                ctl.n_val = 1'b1;
                ctl.mask  = MASK_HVN;
            end
            ALU_RL, ALU_RR, ALU_RLC, ALU_RRC, ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL: begin
                ctl.v_src       = V_PAR;
                ctl.h_fix       = H_ZERO;
                ctl.c_from_unit = 1'b1;     // shifted-out bit
                ctl.mask        = MASK_ALL;
            end
            ALU_BIT, ALU_TSET: begin
                ctl.h_fix = H_ONE;
                ctl.mask  = MASK_ZHN;
            end
            ALU_SCF, ALU_RCF: begin
                ctl.h_fix       = H_ZERO;
                ctl.c_from_unit = 1'b1;
                ctl.mask        = MASK_HNC;
            end
            ALU_CCF, ALU_ZCF: begin
                ctl.c_from_unit = 1'b1;
                ctl.mask        = MASK_NC;
            end
            ALU_LDCF, ALU_ANDCF, ALU_ORCF, ALU_XORCF: begin
                ctl.c_from_unit = 1'b1;
                ctl.mask        = MASK_C;
            end
            default: ;  // SET, RES, CHG leave the flags alone
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/alu900_pkg.sv ====
//****************************************
// ALU900 shared types: opcodes, widths,
// flags, control word and unit results
//****************************************

`default_nettype none

`include "alu900_config.svh"

package alu900_pkg;

    typedef enum logic [`ALU900_SEL_W-1:0] {
        ALU_MOVE, ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_CP, ALU_INC, ALU_DEC,
        ALU_AND, ALU_OR, ALU_XOR, ALU_CPL,
        ALU_RL, ALU_RR, ALU_RLC, ALU_RRC, ALU_SLA, ALU_SRA, ALU_SLL, ALU_SRL,
        ALU_BIT, ALU_SET, ALU_RES, ALU_CHG, ALU_TSET,
        ALU_SCF, ALU_RCF, ALU_CCF, ALU_ZCF, ALU_LDCF, ALU_ANDCF, ALU_ORCF, ALU_XORCF
    } alu_op_e;

    // one-hot, all zero means no write
    typedef struct packed {
        logic long_w;
        logic word_w;
        logic byte_w;
    } width_t;

    typedef struct packed {
        logic s;
        logic z;
        logic gap5;     // always 0
        logic h;
        logic gap3;     // always 0
        logic v;
        logic n;
        logic c;
    } flags_t;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic v;
        logic n;
        logic c;
    } flag_mask_t;

    typedef enum logic [1:0] {V_OVF, V_PAR, V_KEEP} v_src_e;
    typedef enum logic [1:0] {H_CALC, H_ZERO, H_ONE} h_fix_e;

    typedef struct packed {
        alu_op_e    op;
        width_t     w;
        logic       is_arith;       // arith unit result, else bitops
        logic       sub;
        logic       use_carry;      // ADC / SBC
        v_src_e     v_src;
        flag_mask_t mask;
        h_fix_e     h_fix;
        logic       n_val;
        logic       c_from_unit;    // C from c_out instead of per-width carry
    } alu_ctl_t;

    typedef struct packed {
        logic [`ALU900_DW-1:0] value;
        logic [2:0]            cy;  // carry out of bytes 0, 1 and 3
        logic [2:0]            ov;  // overflow at 8, 16 and 32 bits
        logic                  half;
        logic                  c_out;
        logic                  z_out;
    } raw_res_t;

endpackage

`default_nettype wire

// ==== logic/alu900_result.sv ====
//****************************************
// ALU900 result select, flag merge and
// output registers
//****************************************

`default_nettype none

`include "alu900_config.svh"

module alu900_result import alu900_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  alu_ctl_t              ctl,
    input  raw_res_t              arith_res,
    input  raw_res_t              bit_res,
    input  logic                  flag_we,
    output logic [`ALU900_DW-1:0] dout,
    output flags_t                flags,
    output width_t                alu_we,
    output logic                  flag_only
);

    raw_res_t              raw;
    logic [`ALU900_DW-1:0] dout_nx;
    logic                  sign_r;
    logic                  zero_r;
    logic                  par_r;
    logic                  cy_r;
    logic                  ov_r;
    flags_t                flags_nx;
    logic                  wr;
    logic                  flag_wel;    // flag_we at the last enabled edge

    assign raw = ctl.is_arith ? arith_res : bit_res;
    assign wr  = |ctl.w;

    always_comb begin
        if (ctl.w.byte_w) begin
            dout_nx = {dout[31:8], raw.value[7:0]};
            sign_r  = raw.value[7];
            zero_r  = raw.value[7:0] == 8'd0;
            cy_r    = raw.cy[0];
            ov_r    = raw.ov[0];
        end else if (ctl.w.word_w) begin
            dout_nx = {dout[31:16], raw.value[15:0]};
            sign_r  = raw.value[15];
            zero_r  = raw.value[15:0] == 16'd0;
            cy_r    = raw.cy[1];
            ov_r    = raw.ov[1];
        end else begin
            dout_nx = raw.value;
            sign_r  = raw.value[31];
            zero_r  = raw.value == '0;
            cy_r    = raw.cy[2];
            ov_r    = raw.ov[2];
        end
    end

    // even parity, byte or halfword
    assign par_r = ctl.w.byte_w ? ~^raw.value[7:0] : ~^raw.value[15:0];

    always_comb begin
        flags_nx = flags;   // masked-out bits hold
        if (ctl.mask.s)
            flags_nx.s = sign_r;
        if (ctl.mask.z)
            flags_nx.z = ctl.op inside {ALU_BIT, ALU_TSET} ? raw.z_out : zero_r;
        if (ctl.mask.h) begin
            case (ctl.h_fix)
                H_ZERO:  flags_nx.h = 1'b0;
                H_ONE:   flags_nx.h = 1'b1;
                default: flags_nx.h = raw.half;
            endcase
        end
        if (ctl.mask.v) begin
            case (ctl.v_src)
                V_OVF:   flags_nx.v = ov_r;
                V_PAR:   flags_nx.v = par_r;
                default: flags_nx.v = flags.v;
            endcase
        end
        if (ctl.mask.n)
            flags_nx.n = ctl.n_val;
        if (ctl.mask.c)
            flags_nx.c = ctl.c_from_unit ? raw.c_out : cy_r;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout      <= '0;
            flags     <= '0;
            alu_we    <= '0;
            flag_only <= 1'b0;
            flag_wel  <= 1'b0;
        end else if (cen) begin
            flag_wel  <= flag_we;
            alu_we    <= ctl.w;
            flag_only <= flag_we;
            if (wr)
                dout <= dout_nx;
            if (wr || (flag_we && !flag_wel))   // a long flag_we counts once
                flags <= flags_nx;
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu900_top.sv ====
//****************************************
// ALU900 top level: decode, arith and
// bitops units, result stage
//****************************************

`default_nettype none

`include "alu900_config.svh"

module alu900_top import alu900_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cen,
    input  logic [`ALU900_DW-1:0] op0,      // destination
    input  logic [`ALU900_DW-1:0] op1,      // source
    input  logic [`ALU900_DW-1:0] imm,
    input  logic                  sel_imm,
    input  logic                  flag_we,
    input  width_t                w,
    input  alu_op_e               sel,
    output logic [`ALU900_DW-1:0] dout,
    output flags_t                flags,
    output width_t                alu_we,
    output logic                  flag_only
);

    alu_ctl_t              ctl;
    logic [`ALU900_DW-1:0] op2;
    raw_res_t              arith_res;
    raw_res_t              bit_res;

    alu900_decode u_decode (
        .op      (sel),
        .w       (w),
        .sel_imm (sel_imm),
        .op1     (op1),
        .imm     (imm),
        .ctl     (ctl),
        .op2     (op2)
    );

    alu900_arith u_arith (
        .ctl   (ctl),
        .op0   (op0),
        .op2   (op2),
        .carry (flags.c),   // old carry for ADC / SBC
        .res   (arith_res)
    );

    alu900_bitops u_bitops (
        .ctl (ctl),
        .op0 (op0),
        .op2 (op2),
        .cur (flags),
        .res (bit_res)
    );

    alu900_result u_result (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ctl       (ctl),
        .arith_res (arith_res),
        .bit_res   (bit_res),
        .flag_we   (flag_we),
        .dout      (dout),
        .flags     (flags),
        .alu_we    (alu_we),
        .flag_only (flag_only)
    );

endmodule

`default_nettype wire

// ==== verif/alu900_tb.sv ====
//****************************************
// ALU900 testbench: clock and reset, an
// operation table with expected results,
// hold checks on idle cycles, summary
//****************************************

`default_nettype none

`include "alu900_config.svh"

module alu900_tb import alu900_pkg::*; ();

    localparam width_t WN = 3'b000;
    localparam width_t WB = 3'b001;
    localparam width_t WW = 3'b010;
    localparam width_t WL = 3'b100;
    localparam int NROWS    = 39;
    localparam int EDGE_TMO = 20;     // polls before a missing edge ends the run

    typedef struct packed {
        alu_op_e               sel;
        width_t                w;
        logic [`ALU900_DW-1:0] op0;
        logic [`ALU900_DW-1:0] op1;
        logic [`ALU900_DW-1:0] imm;
        logic                  sel_imm;
        logic                  flag_we;
        logic [`ALU900_DW-1:0] exp_dout;
        flags_t                exp_flags;  // s z - h - v n c
    } row_t;

    // rows chain on the dout and flags left by the row before
    localparam row_t ROWS [0:NROWS-1] = '{
        '{ALU_MOVE,  WL, 32'h00000000, 32'h12345678, 32'h0, 1'b0, 1'b0, 32'h12345678, 8'h00},
        '{ALU_ADD,   WB, 32'h0000003A, 32'h000000C6, 32'h0, 1'b0, 1'b0, 32'h12345600, 8'h51},
        '{ALU_ADC,   WW, 32'h00007FFF, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h12348000, 8'h94},
        '{ALU_SUB,   WL, 32'h00000000, 32'h00000001, 32'h0, 1'b0, 1'b0, 32'hFFFFFFFF, 8'h93},
        '{ALU_SBC,   WB, 32'h00000080, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'hFFFFFF7F, 8'h16},
        '{ALU_CP,    WW, 32'h00001234, 32'hDEADBEEF, 32'h1234, 1'b1, 1'b0, 32'hFFFF0000, 8'h42},
        '{ALU_CP,    WN, 32'h00000005, 32'h00000009, 32'h0, 1'b0, 1'b0, 32'hFFFF0000, 8'h42},
        '{ALU_ADD,   WL, 32'h7FFFFFFF, 32'h00000001, 32'h0, 1'b0, 1'b0, 32'h80000000, 8'h94},
        '{ALU_ADD,   WL, 32'hFFFFFFFF, 32'h00000001, 32'h0, 1'b0, 1'b0, 32'h00000000, 8'h51},
        // inc keeps C and a word-width dec keeps all flags
        '{ALU_INC,   WB, 32'h0000007F, 32'h00000001, 32'h0, 1'b0, 1'b0, 32'h00000080, 8'h95},
        '{ALU_ADC,   WL, 32'h00000001, 32'h00000002, 32'h0, 1'b0, 1'b0, 32'h00000004, 8'h00},
        '{ALU_DEC,   WB, 32'h00000000, 32'h00000001, 32'h0, 1'b0, 1'b0, 32'h000000FF, 8'h92},
        '{ALU_DEC,   WW, 32'h00001000, 32'h00000001, 32'h0, 1'b0, 1'b0, 32'h00000FFF, 8'h92},
        '{ALU_AND,   WB, 32'h000000F0, 32'h0000003C, 32'h0, 1'b0, 1'b0, 32'h00000F30, 8'h14},
        '{ALU_OR,    WW, 32'h00001200, 32'h00000034, 32'h0, 1'b0, 1'b0, 32'h00001234, 8'h00},
        '{ALU_XOR,   WL, 32'h800000FF, 32'h000000FF, 32'h0, 1'b0, 1'b0, 32'h80000000, 8'h84},
        '{ALU_CPL,   WB, 32'h00000000, 32'h00000055, 32'h0, 1'b0, 1'b0, 32'h800000AA, 8'h96},
        // flag ops alternate with shifts so flag_we drops in between
        '{ALU_SCF,   WN, 32'h00000000, 32'h00000000, 32'h0, 1'b0, 1'b1, 32'h800000AA, 8'h85},
        '{ALU_CCF,   WN, 32'h00000000, 32'h00000000, 32'h0, 1'b0, 1'b1, 32'h800000AA, 8'h85},
        '{ALU_RLC,   WB, 32'h00000081, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h80000003, 8'h05},
        '{ALU_CCF,   WN, 32'h00000000, 32'h00000000, 32'h0, 1'b0, 1'b1, 32'h80000003, 8'h04},
        '{ALU_RL,    WW, 32'h0000C001, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h80008002, 8'h85},
        '{ALU_RCF,   WN, 32'h00000000, 32'h00000000, 32'h0, 1'b0, 1'b1, 32'h80008002, 8'h84},
        '{ALU_SRL,   WW, 32'h00000002, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h80000001, 8'h00},
        '{ALU_ZCF,   WN, 32'h00000000, 32'h00000000, 32'h0, 1'b0, 1'b1, 32'h80000001, 8'h01},
        '{ALU_RR,    WB, 32'h00000002, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h80000081, 8'h84},
        '{ALU_LDCF,  WN, 32'h00000100, 32'h00000000, 32'h8, 1'b1, 1'b1, 32'h80000081, 8'h85},
        '{ALU_SRA,   WB, 32'h00000084, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h800000C2, 8'h80},
        '{ALU_ORCF,  WN, 32'h00008000, 32'h00000000, 32'hF, 1'b1, 1'b1, 32'h800000C2, 8'h81},
        '{ALU_SLA,   WB, 32'h000000C0, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h80000080, 8'h81},
        '{ALU_ANDCF, WN, 32'h00000000, 32'h00000000, 32'h3, 1'b1, 1'b1, 32'h80000080, 8'h80},
        '{ALU_SLL,   WW, 32'h00008001, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h80000002, 8'h01},
        '{ALU_XORCF, WN, 32'h00000001, 32'h00000000, 32'h0, 1'b1, 1'b1, 32'h80000002, 8'h00},
        '{ALU_RRC,   WL, 32'h00000003, 32'h00000000, 32'h0, 1'b0, 1'b0, 32'h80000001, 8'h81},
        // bit index comes from imm
        '{ALU_BIT,   WW, 32'h00000010, 32'h00000000, 32'h4, 1'b1, 1'b0, 32'h80000010, 8'h91},
        '{ALU_SET,   WW, 32'h00000000, 32'h00000000, 32'hF, 1'b1, 1'b0, 32'h80008000, 8'h91},
        '{ALU_RES,   WL, 32'hFFFFFFFF, 32'h00000000, 32'h3, 1'b1, 1'b0, 32'hFFFFFFF7, 8'h91},
        '{ALU_CHG,   WB, 32'h00000001, 32'h00000000, 32'h0, 1'b1, 1'b0, 32'hFFFFFF00, 8'h91},
        '{ALU_TSET,  WW, 32'h00000000, 32'h00000000, 32'h7, 1'b1, 1'b0, 32'hFFFF0080, 8'hD1}
    };

    logic                  clk;
    logic                  rst;
    logic                  cen;
    logic [`ALU900_DW-1:0] op0;
    logic [`ALU900_DW-1:0] op1;
    logic [`ALU900_DW-1:0] imm;
    logic                  sel_imm;
    logic                  flag_we;
    width_t                w;
    alu_op_e               sel;
    logic [`ALU900_DW-1:0] dout;
    flags_t                flags;
    width_t                alu_we;
    logic                  flag_only;
    int                    cycle = 0;
    int                    errors;
    int                    checks;
    string                 where;

    alu900_top UUT (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .op0       (op0),
        .op1       (op1),
        .imm       (imm),
        .sel_imm   (sel_imm),
        .flag_we   (flag_we),
        .w         (w),
        .sel       (sel),
        .dout      (dout),
        .flags     (flags),
        .alu_we    (alu_we),
        .flag_only (flag_only)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;     // rising edges on odd times
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // polls on even times only, returns one unit after the edge
    task automatic wait_edge();
        int start;
        int guard;
        start = cycle;
        guard = 0;
        while (cycle == start && guard < EDGE_TMO) begin
            #2;
            guard++;
        end
        if (cycle == start) begin
            $display("timeout: no rising clock edge after %0d polls (%s)", EDGE_TMO, where);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s %s: got 0x%h, expected 0x%h", where, name, got, exp);
        end
    endtask

    task automatic check_outputs(input row_t r);
        check("dout", dout, r.exp_dout);
        check("flags", 32'(flags), 32'(r.exp_flags));
        check("alu_we", 32'(alu_we), 32'(r.w));        // w one edge later
        check("flag_only", 32'(flag_only), 32'(r.flag_we));
    endtask

    task automatic apply_row(input row_t r);
        sel     = r.sel;
        w       = r.w;
        op0     = r.op0;
        op1     = r.op1;
        imm     = r.imm;
        sel_imm = r.sel_imm;
        flag_we = r.flag_we;
        cen     = 1'b1;
    endtask

    initial begin
        int idle;
        void'($urandom(32'h5722_65b4));
        errors   = 0;
        checks   = 0;
        where    = "reset";
        rst      = 1'b1;
        cen      = 1'b0;
        sel      = ALU_MOVE;
        w        = WN;
        op0      = '0;
        op1      = '0;
        imm      = '0;
        sel_imm  = 1'b0;
        flag_we  = 1'b0;
        repeat (5) wait_edge();
        rst = 1'b0;
        check_outputs('0);
        for (int i = 0; i < NROWS; i++) begin
            where = $sformatf("row %0d", i);
            apply_row(ROWS[i]);
            wait_edge();
            check_outputs(ROWS[i]);
            // cen low with operands, width and flag_we all changed
            idle    = int'($urandom % 4);
            where   = $sformatf("row %0d idle", i);
            cen     = 1'b0;
            op0     = $urandom;
            op1     = $urandom;
            flag_we = ~ROWS[i].flag_we;
            w       = ROWS[i].w == WN ? WB : {w.word_w, w.byte_w, w.long_w};
            for (int k = 0; k < idle; k++) begin
                wait_edge();
                check_outputs(ROWS[i]);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
